// ==== src/raster_cfg.svh ====
`ifndef RASTER_CFG_SVH
`define RASTER_CFG_SVH

// fixed-point word, Q16.16 by default.
`define WORD_WIDTH  32
`define DECIMAL_POS 16

`define SCREEN_W 320
`define SCREEN_H 240

`define FRAG_DEPTH 8 // fragment FIFO entries.

`define AXI_ADDR_W 6

`endif

// ==== src/raster_pkg.sv ====
`include "raster_cfg.svh"

package raster_pkg;

    typedef logic signed [`WORD_WIDTH-1:0] fix_t;
    typedef logic [$clog2(`SCREEN_W > `SCREEN_H ? `SCREEN_W : `SCREEN_H)-1:0] coord_t;
    typedef logic [$clog2(`FRAG_DEPTH + 1)-1:0] count_t;
    typedef logic [`AXI_ADDR_W-1:0] addr_t;

    localparam fix_t FIX_ONE = fix_t'(1) <<< `DECIMAL_POS;

    // byte offsets of the 32-bit registers.
    localparam addr_t REG_CTRL     = 6'h00;
    localparam addr_t REG_STATUS   = 6'h04;
    localparam addr_t REG_V0X      = 6'h08;
    localparam addr_t REG_V0Y      = 6'h0C;
    localparam addr_t REG_V1X      = 6'h10;
    localparam addr_t REG_V1Y      = 6'h14;
    localparam addr_t REG_V2X      = 6'h18;
    localparam addr_t REG_V2Y      = 6'h1C;
    localparam addr_t REG_FRAG_POS = 6'h20;
    localparam addr_t REG_FRAG_L0  = 6'h24;
    localparam addr_t REG_FRAG_L1  = 6'h28;
    localparam addr_t REG_FRAG_L2  = 6'h2C;
    localparam addr_t REG_FRAG_POP = 6'h30;

endpackage

// ==== src/bary_pipe.sv ====
`timescale 1ns/1ps
`include "raster_cfg.svh"

module bary_pipe (
    input  logic                clk_i,
    input  logic                nrst_i,
    input  logic                run_i,
    input  logic                continue_i,
    output logic                ready_o,
    input  raster_pkg::coord_t  posx_i,
    input  raster_pkg::coord_t  posy_i,
    input  raster_pkg::fix_t    v0x_i,
    input  raster_pkg::fix_t    v0y_i,
    input  raster_pkg::fix_t    v1x_i,
    input  raster_pkg::fix_t    v1y_i,
    input  raster_pkg::fix_t    v2x_i,
    input  raster_pkg::fix_t    v2y_i,
    output raster_pkg::fix_t    l0_o,
    output raster_pkg::fix_t    l1_o,
    output raster_pkg::fix_t    l2_o
);
    import raster_pkg::*;

    localparam logic [4:0] ST_IDLE  = 5'd0;
    localparam logic [4:0] ST_SET8  = 5'd8;
    localparam logic [4:0] ST_AWAIT = 5'd9;
    localparam logic [4:0] ST_RUN1  = 5'd10;
    localparam logic [4:0] ST_RUN9  = 5'd18;

    logic [4:0] state;
    logic [4:0] state_nxt;

    // operand registers of the shared subtractor, adder and multiplier.
    fix_t s_a, s_b, a_a, a_b, m_a, m_b;
    fix_t sub_y, add_y, mul_y;

    fix_t y1my2, x0mx2, x2mx1, y2my0;
    fix_t y1py0, y2py1;
    fix_t temp1, temp2;
    fix_t det, inv_det;
    fix_t px_fix, py_fix;

    function automatic fix_t fmul(fix_t a, fix_t b);
        logic signed [2*`WORD_WIDTH-1:0] p;
        p = a * b;
        return fix_t'(p >>> `DECIMAL_POS);
    endfunction

    function automatic fix_t frecip(fix_t d);
        logic signed [2*`WORD_WIDTH-1:0] one_sq;
        one_sq = '0;
        one_sq[2*`DECIMAL_POS] = 1'b1;
        return (d == '0) ? '0 : fix_t'(one_sq / d); // degenerate triangles get culled anyway.
    endfunction

    assign sub_y  = s_a - s_b;
    assign add_y  = a_a + a_b;
    assign mul_y  = fmul(m_a, m_b);
    assign px_fix = fix_t'(posx_i) <<< `DECIMAL_POS;
    assign py_fix = fix_t'(posy_i) <<< `DECIMAL_POS;

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE:  if (run_i) state_nxt = ST_IDLE + 5'd1;
            ST_AWAIT: begin
                if (run_i) state_nxt = ST_IDLE + 5'd1;
                else if (continue_i) state_nxt = ST_RUN1;
            end
            // the area sum sits at the adder output during the last setup state.
            ST_SET8:  state_nxt = (add_y < 0) ? ST_AWAIT : ST_IDLE;
            ST_RUN9:  state_nxt = ST_AWAIT;
            default:  state_nxt = state + 5'd1;
        endcase
    end

    always_ff @(posedge clk_i or negedge nrst_i) begin
        if (!nrst_i) state <= ST_IDLE;
        else state <= state_nxt;
    end

    always_ff @(posedge clk_i) begin
        case (state)
            ST_IDLE, ST_AWAIT: begin
                if (run_i) begin
                    s_a <= v1y_i;
                    s_b <= v2y_i;
                    a_a <= v1y_i;
                    a_b <= v0y_i;
                end else if (state == ST_AWAIT && continue_i) begin
                    s_a <= px_fix;
                    s_b <= v2x_i;
                    temp1 <= py_fix;
                end
            end
            5'd1: begin
                y1my2 <= sub_y;
                y1py0 <= add_y;
                s_a <= v0x_i;
                s_b <= v2x_i;
                a_a <= v2y_i;
                a_b <= v1y_i;
            end
            5'd2: begin
                x0mx2 <= sub_y;
                y2py1 <= add_y;
                s_a <= v2x_i;
                s_b <= v1x_i;
                a_a <= v0y_i;
                a_b <= v2y_i;
                m_a <= y1my2;
                m_b <= sub_y;
            end
            5'd3: begin
                x2mx1 <= sub_y;
                temp1 <= mul_y; // first determinant term.
                s_a <= v0y_i;
                s_b <= v2y_i;
                m_a <= x0mx2;
                m_b <= add_y;   // area term of edge 2 to 0.
            end
            5'd4: begin
                temp2 <= mul_y;
                s_a <= v1x_i;
                s_b <= v0x_i;
                m_a <= x2mx1;
                m_b <= sub_y;
            end
            5'd5: begin
                a_a <= temp1;
                a_b <= mul_y;
                s_a <= v2y_i;
                s_b <= v0y_i;
                m_a <= sub_y;
                m_b <= y1py0;
            end
            5'd6: begin
                y2my0 <= sub_y;
                det <= add_y;
                a_a <= temp2;
                a_b <= mul_y;
                m_a <= x2mx1;
                m_b <= y2py1;
            end
            5'd7: begin
                inv_det <= frecip(det);
                a_a <= add_y;
                a_b <= mul_y;
            end
            ST_RUN1: begin
                temp1 <= sub_y; // px - x2, kept for the second edge.
                s_a <= temp1;
                s_b <= v2y_i;
                m_a <= y1my2;
                m_b <= sub_y;
            end
            5'd11: begin
                temp2 <= sub_y; // py - y2.
                a_a <= mul_y;
                m_a <= x2mx1;
                m_b <= sub_y;
            end
            5'd12: begin
                a_b <= mul_y;
                m_a <= y2my0;
                m_b <= temp1;
            end
            5'd13: begin
                a_a <= mul_y;
                m_a <= add_y;
                m_b <= inv_det;
            end
            5'd14: begin
                l0_o <= mul_y;
                m_a <= x0mx2;
                m_b <= temp2;
            end
            5'd15: a_b <= mul_y;
            5'd16: begin
                m_a <= add_y;
                m_b <= inv_det;
                s_a <= FIX_ONE;
                s_b <= l0_o;
            end
            5'd17: begin
                l1_o <= mul_y;
                s_a <= sub_y;
                s_b <= mul_y;
            end
            ST_RUN9: l2_o <= sub_y;
            default: ;
        endcase
    end

    assign ready_o = (state == ST_AWAIT);

    // continue only arrives while the unit waits with ready high.
    a_cont_ready: assert property (@(posedge clk_i) disable iff (!nrst_i)
        continue_i |-> ready_o);

endmodule

// ==== src/raster_scan.sv ====
`timescale 1ns/1ps
`include "raster_cfg.svh"

module raster_scan (
    input  logic                clk_i,
    input  logic                nrst_i,
    input  logic                start_i,
    input  raster_pkg::fix_t    v0x_i,
    input  raster_pkg::fix_t    v0y_i,
    input  raster_pkg::fix_t    v1x_i,
    input  raster_pkg::fix_t    v1y_i,
    input  raster_pkg::fix_t    v2x_i,
    input  raster_pkg::fix_t    v2y_i,
    output logic                busy_o,
    output logic                culled_o,
    output logic                run_o,
    output logic                cont_o,
    output raster_pkg::coord_t  pos_x_o,
    output raster_pkg::coord_t  pos_y_o,
    input  logic                bary_ready_i,
    input  raster_pkg::fix_t    l0_i,
    input  raster_pkg::fix_t    l1_i,
    input  raster_pkg::fix_t    l2_i,
    input  logic                full_i,
    output logic                push_o,
    output raster_pkg::coord_t  frag_x_o,
    output raster_pkg::coord_t  frag_y_o,
    output raster_pkg::fix_t    frag_l0_o,
    output raster_pkg::fix_t    frag_l1_o,
    output raster_pkg::fix_t    frag_l2_o
);
    import raster_pkg::*;

    localparam logic [1:0] S_IDLE  = 2'd0;
    localparam logic [1:0] S_SETUP = 2'd1;
    localparam logic [1:0] S_RUN   = 2'd2;
    localparam logic [3:0] SETUP_CYCLES = 4'd9;

    logic [1:0] state;
    logic [3:0] cnt;
    coord_t bb_x0, bb_x1, bb_y0, bb_y1;
    coord_t bx0, bx1, by0, by1;
    coord_t cur_x, cur_y;
    logic last_q, covered, first, step;

    function automatic fix_t min3(fix_t a, fix_t b, fix_t c);
        fix_t m;
        m = (a < b) ? a : b;
        return (c < m) ? c : m;
    endfunction

    function automatic fix_t max3(fix_t a, fix_t b, fix_t c);
        fix_t m;
        m = (a > b) ? a : b;
        return (c > m) ? c : m;
    endfunction

    // integer part of a coordinate, clamped into [0, lim-1].
    function automatic coord_t to_pix(fix_t v, int lim);
        fix_t ip;
        ip = v >>> `DECIMAL_POS;
        if (ip < 0) return '0;
        if (ip > lim - 1) return coord_t'(lim - 1);
        return coord_t'(ip);
    endfunction

    assign bb_x0 = to_pix(min3(v0x_i, v1x_i, v2x_i), `SCREEN_W);
    assign bb_x1 = to_pix(max3(v0x_i, v1x_i, v2x_i), `SCREEN_W);
    assign bb_y0 = to_pix(min3(v0y_i, v1y_i, v2y_i), `SCREEN_H);
    assign bb_y1 = to_pix(max3(v0y_i, v1y_i, v2y_i), `SCREEN_H);

    assign covered = (l0_i >= 0) && (l1_i >= 0) && (l2_i >= 0);
    assign first   = (state == S_SETUP) && (cnt == '0) && bary_ready_i;
    assign step    = (state == S_RUN) && bary_ready_i && !(covered && full_i); // hold while full.

    assign run_o   = (state == S_IDLE) && start_i;
    assign cont_o  = first || (step && !last_q);
    assign push_o  = step && covered;
    assign busy_o  = (state != S_IDLE);
    assign pos_x_o = cur_x;
    assign pos_y_o = cur_y;
    assign frag_l0_o = l0_i;
    assign frag_l1_o = l1_i;
    assign frag_l2_o = l2_i;

    always_ff @(posedge clk_i or negedge nrst_i) begin
        if (!nrst_i) begin
            state <= S_IDLE;
            cnt <= '0;
            culled_o <= 1'b0;
        end else begin
            case (state)
                S_IDLE: if (start_i) begin
                    state <= S_SETUP;
                    cnt <= SETUP_CYCLES - 4'd1;
                    culled_o <= 1'b0;
                end
                S_SETUP: begin
                    if (cnt != '0) cnt <= cnt - 4'd1;
                    else if (bary_ready_i) state <= S_RUN;
                    else begin
                        culled_o <= 1'b1; // setup ended without ready.
                        state <= S_IDLE;
                    end
                end
                S_RUN: if (step && last_q) state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (run_o) begin
            bx0 <= bb_x0;
            bx1 <= bb_x1;
            by0 <= bb_y0;
            by1 <= bb_y1;
            cur_x <= bb_x0;
            cur_y <= bb_y0;
        end
        if (cont_o) begin
            frag_x_o <= cur_x; // weights returned next belong to this pixel.
            frag_y_o <= cur_y;
            last_q <= (cur_x == bx1) && (cur_y == by1);
            if (cur_x == bx1) begin
                cur_x <= bx0;
                cur_y <= cur_y + 1'b1;
            end else begin
                cur_x <= cur_x + 1'b1;
            end
        end
    end

    // every fragment lies inside the latched bounding box.
    a_frag_in_box: assert property (@(posedge clk_i) disable iff (!nrst_i)
        push_o |-> (frag_x_o >= bx0) && (frag_x_o <= bx1)
            && (frag_y_o >= by0) && (frag_y_o <= by1));

endmodule

// ==== src/frag_fifo.sv ====
`timescale 1ns/1ps
`include "raster_cfg.svh"

module frag_fifo (
    input  logic                clk_i,
    input  logic                nrst_i,
    input  logic                push_i,
    input  raster_pkg::coord_t  x_i,
    input  raster_pkg::coord_t  y_i,
    input  raster_pkg::fix_t    l0_i,
    input  raster_pkg::fix_t    l1_i,
    input  raster_pkg::fix_t    l2_i,
    input  logic                pop_i,
    output raster_pkg::coord_t  x_o,
    output raster_pkg::coord_t  y_o,
    output raster_pkg::fix_t    l0_o,
    output raster_pkg::fix_t    l1_o,
    output raster_pkg::fix_t    l2_o,
    output raster_pkg::count_t  count_o,
    output logic                full_o,
    output logic                empty_o
);
    import raster_pkg::*;

    localparam int AW = $clog2(`FRAG_DEPTH);
    localparam logic [AW-1:0] LAST = AW'(`FRAG_DEPTH - 1);

    coord_t mem_x [`FRAG_DEPTH];
    coord_t mem_y [`FRAG_DEPTH];
    fix_t mem_l0 [`FRAG_DEPTH];
    fix_t mem_l1 [`FRAG_DEPTH];
    fix_t mem_l2 [`FRAG_DEPTH];
    logic [AW-1:0] wr_ptr, rd_ptr;

    always_ff @(posedge clk_i or negedge nrst_i) begin
        if (!nrst_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count_o <= '0;
        end else begin
            if (push_i) wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
            if (pop_i) rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
            if (push_i && !pop_i) count_o <= count_o + 1'b1;
            else if (pop_i && !push_i) count_o <= count_o - 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            mem_x[wr_ptr] <= x_i;
            mem_y[wr_ptr] <= y_i;
            mem_l0[wr_ptr] <= l0_i;
            mem_l1[wr_ptr] <= l1_i;
            mem_l2[wr_ptr] <= l2_i;
        end
    end

    assign x_o = mem_x[rd_ptr];
    assign y_o = mem_y[rd_ptr];
    assign l0_o = mem_l0[rd_ptr];
    assign l1_o = mem_l1[rd_ptr];
    assign l2_o = mem_l2[rd_ptr];
    assign full_o = (count_o == count_t'(`FRAG_DEPTH));
    assign empty_o = (count_o == '0);

    a_no_overrun: assert property (@(posedge clk_i) disable iff (!nrst_i)
        !(push_i && full_o) && !(pop_i && empty_o));

endmodule

// ==== src/raster_regs.sv ====
`timescale 1ns/1ps
`include "raster_cfg.svh"

module raster_regs (
    input  logic                clk_i,
    input  logic                nrst_i,
    input  raster_pkg::addr_t   s_awaddr_i,
    input  logic                s_awvalid_i,
    output logic                s_awready_o,
    input  logic [31:0]         s_wdata_i,
    input  logic                s_wvalid_i,
    output logic                s_wready_o,
    output logic                s_bvalid_o,
    input  logic                s_bready_i,
    input  raster_pkg::addr_t   s_araddr_i,
    input  logic                s_arvalid_i,
    output logic                s_arready_o,
    output logic [31:0]         s_rdata_o,
    output logic                s_rvalid_o,
    input  logic                s_rready_i,
    output logic                start_o,
    output raster_pkg::fix_t    v0x_o,
    output raster_pkg::fix_t    v0y_o,
    output raster_pkg::fix_t    v1x_o,
    output raster_pkg::fix_t    v1y_o,
    output raster_pkg::fix_t    v2x_o,
    output raster_pkg::fix_t    v2y_o,
    input  logic                busy_i,
    input  logic                culled_i,
    input  raster_pkg::coord_t  frag_x_i,
    input  raster_pkg::coord_t  frag_y_i,
    input  raster_pkg::fix_t    frag_l0_i,
    input  raster_pkg::fix_t    frag_l1_i,
    input  raster_pkg::fix_t    frag_l2_i,
    input  raster_pkg::count_t  count_i,
    input  logic                empty_i,
    output logic                pop_o
);
    import raster_pkg::*;

    logic wr_en, rd_en;
    logic [31:0] rd_mux;

    // a new request is taken only once the previous response has gone.
    assign wr_en = s_awvalid_i && s_wvalid_i && !s_bvalid_o;
    assign rd_en = s_arvalid_i && !s_rvalid_o;
    assign s_awready_o = wr_en;
    assign s_wready_o = wr_en;
    assign s_arready_o = rd_en;

    always_comb begin
        rd_mux = '0;
        case (s_araddr_i)
            REG_STATUS: begin
                rd_mux[0] = busy_i;
                rd_mux[1] = culled_i;
                rd_mux[8 +: $bits(count_t)] = count_i;
            end
            REG_V0X:      rd_mux = v0x_o;
            REG_V0Y:      rd_mux = v0y_o;
            REG_V1X:      rd_mux = v1x_o;
            REG_V1Y:      rd_mux = v1y_o;
            REG_V2X:      rd_mux = v2x_o;
            REG_V2Y:      rd_mux = v2y_o;
            REG_FRAG_POS: begin
                rd_mux[0 +: $bits(coord_t)] = frag_x_i;
                rd_mux[16 +: $bits(coord_t)] = frag_y_i;
                rd_mux[31] = !empty_i; // head entry is valid.
            end
            REG_FRAG_L0:  rd_mux = frag_l0_i;
            REG_FRAG_L1:  rd_mux = frag_l1_i;
            REG_FRAG_L2:  rd_mux = frag_l2_i;
            default:      rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk_i or negedge nrst_i) begin
        if (!nrst_i) begin
            s_bvalid_o <= 1'b0;
            s_rvalid_o <= 1'b0;
            start_o <= 1'b0;
            pop_o <= 1'b0;
        end else begin
            if (wr_en) s_bvalid_o <= 1'b1;
            else if (s_bready_i) s_bvalid_o <= 1'b0;
            if (rd_en) s_rvalid_o <= 1'b1;
            else if (s_rready_i) s_rvalid_o <= 1'b0;
            start_o <= wr_en && (s_awaddr_i == REG_CTRL) && s_wdata_i[0];
            pop_o <= wr_en && (s_awaddr_i == REG_FRAG_POP) && !empty_i; // pops of an empty FIFO are dropped.
        end
    end

    always_ff @(posedge clk_i) begin
        if (rd_en) s_rdata_o <= rd_mux;
        if (wr_en) begin
            case (s_awaddr_i)
                REG_V0X: v0x_o <= s_wdata_i;
                REG_V0Y: v0y_o <= s_wdata_i;
                REG_V1X: v1x_o <= s_wdata_i;
                REG_V1Y: v1y_o <= s_wdata_i;
                REG_V2X: v2x_o <= s_wdata_i;
                REG_V2Y: v2y_o <= s_wdata_i;
                default: ;
            endcase
        end
    end

    a_pop_nonempty: assert property (@(posedge clk_i) disable iff (!nrst_i)
        pop_o |-> !empty_i);

endmodule

// ==== src/raster_top.sv ====
`timescale 1ns/1ps
`include "raster_cfg.svh"

module raster_top (
    input  logic                clk_i,
    input  logic                nrst_i,
    input  raster_pkg::addr_t   s_awaddr_i,
    input  logic                s_awvalid_i,
    output logic                s_awready_o,
    input  logic [31:0]         s_wdata_i,
    input  logic                s_wvalid_i,
    output logic                s_wready_o,
    output logic                s_bvalid_o,
    input  logic                s_bready_i,
    input  raster_pkg::addr_t   s_araddr_i,
    input  logic                s_arvalid_i,
    output logic                s_arready_o,
    output logic [31:0]         s_rdata_o,
    output logic                s_rvalid_o,
    input  logic                s_rready_i
);
    import raster_pkg::*;

    logic start, busy, culled, run, cont, bary_ready, push, pop, full, empty;
    fix_t v0x, v0y, v1x, v1y, v2x, v2y;
    fix_t l0, l1, l2, fl0, fl1, fl2, hl0, hl1, hl2;
    coord_t pos_x, pos_y, fx, fy, hx, hy;
    count_t count;

    raster_regs u_regs (
        .clk_i, .nrst_i, .s_awaddr_i, .s_awvalid_i, .s_awready_o, .s_wdata_i,
        .s_wvalid_i, .s_wready_o, .s_bvalid_o, .s_bready_i, .s_araddr_i,
        .s_arvalid_i, .s_arready_o, .s_rdata_o, .s_rvalid_o, .s_rready_i,
        .start_o(start), .v0x_o(v0x), .v0y_o(v0y), .v1x_o(v1x), .v1y_o(v1y),
        .v2x_o(v2x), .v2y_o(v2y), .busy_i(busy), .culled_i(culled),
        .frag_x_i(hx), .frag_y_i(hy), .frag_l0_i(hl0), .frag_l1_i(hl1),
        .frag_l2_i(hl2), .count_i(count), .empty_i(empty), .pop_o(pop)
    );

    raster_scan u_scan (
        .clk_i, .nrst_i, .start_i(start),
        .v0x_i(v0x), .v0y_i(v0y), .v1x_i(v1x), .v1y_i(v1y), .v2x_i(v2x), .v2y_i(v2y),
        .busy_o(busy), .culled_o(culled), .run_o(run), .cont_o(cont),
        .pos_x_o(pos_x), .pos_y_o(pos_y), .bary_ready_i(bary_ready),
        .l0_i(l0), .l1_i(l1), .l2_i(l2), .full_i(full), .push_o(push),
        .frag_x_o(fx), .frag_y_o(fy), .frag_l0_o(fl0), .frag_l1_o(fl1), .frag_l2_o(fl2)
    );

    bary_pipe u_bary (
        .clk_i, .nrst_i, .run_i(run), .continue_i(cont), .ready_o(bary_ready),
        .posx_i(pos_x), .posy_i(pos_y),
        .v0x_i(v0x), .v0y_i(v0y), .v1x_i(v1x), .v1y_i(v1y), .v2x_i(v2x), .v2y_i(v2y),
        .l0_o(l0), .l1_o(l1), .l2_o(l2)
    );

    frag_fifo u_fifo (
        .clk_i, .nrst_i, .push_i(push),
        .x_i(fx), .y_i(fy), .l0_i(fl0), .l1_i(fl1), .l2_i(fl2), .pop_i(pop),
        .x_o(hx), .y_o(hy), .l0_o(hl0), .l1_o(hl1), .l2_o(hl2),
        .count_o(count), .full_o(full), .empty_o(empty)
    );

endmodule

// ==== verif/tb_raster.sv ====
`timescale 1ns/1ps
`include "raster_cfg.svh"

module tb_raster;
    import raster_pkg::*;

    localparam int HS_TIMEOUT = 100;   // cycles allowed per AXI handshake.
    localparam int RUN_TIMEOUT = 3000; // status polls allowed per run.
    localparam int NUM_TRI = 4;
    localparam int CW = $bits(count_t);
    localparam longint ONE = longint'(1) << `DECIMAL_POS;

    logic clk_i;
    logic nrst_i;
    addr_t awaddr;
    addr_t araddr;
    logic awvalid, awready, wvalid, wready, bvalid, bready;
    logic arvalid, arready, rvalid, rready;
    logic [31:0] wdata;
    logic [31:0] rdata;

    // triangle table: integer vertices, expected cull flag and fragment count.
    int tri_v [NUM_TRI][6];
    bit tri_culled [NUM_TRI];
    int tri_nfrag [NUM_TRI];

    int exp_x[$];
    int exp_y[$];
    longint exp_l0[$];
    longint exp_l1[$];
    int errors, test_errors, tests_run, tests_failed;
    logic [31:0] rng_state;

    raster_top uut (
        .clk_i(clk_i), .nrst_i(nrst_i),
        .s_awaddr_i(awaddr), .s_awvalid_i(awvalid), .s_awready_o(awready),
        .s_wdata_i(wdata), .s_wvalid_i(wvalid), .s_wready_o(wready),
        .s_bvalid_o(bvalid), .s_bready_i(bready),
        .s_araddr_i(araddr), .s_arvalid_i(arvalid), .s_arready_o(arready),
        .s_rdata_o(rdata), .s_rvalid_o(rvalid), .s_rready_i(rready)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic logic [31:0] fix_word(input int v);
        return 32'(v) << `DECIMAL_POS;
    endfunction

    task automatic abort_run(input string what);
        $display("timeout while waiting for %s at %0t", what, $time);
        $display("Some tests failed");
        $finish;
    endtask

    task automatic report_mismatch(input string what, input longint got, input longint exp);
        $display("** Error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
        test_errors++;
    endtask

    task automatic close_test(input string name);
        tests_run++;
        errors += test_errors;
        if (test_errors == 0) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: FAILED with %0d errors", name, test_errors);
            tests_failed++;
        end
    endtask

    task automatic write_reg(input addr_t addr, input logic [31:0] data);
        int waited;
        @(posedge clk_i);
        awaddr <= addr;
        wdata <= data;
        awvalid <= 1'b1;
        wvalid <= 1'b1;
        bready <= 1'b1;
        waited = 0;
        do begin
            @(negedge clk_i);
            waited++;
        end while (!(awready && wready) && waited < HS_TIMEOUT);
        if (!(awready && wready)) abort_run("write address and data ready");
        @(posedge clk_i);
        awvalid <= 1'b0;
        wvalid <= 1'b0;
        waited = 0;
        do begin
            @(negedge clk_i);
            waited++;
        end while (!bvalid && waited < HS_TIMEOUT);
        if (!bvalid) abort_run("write response");
        @(posedge clk_i);
        bready <= 1'b0;
    endtask

    task automatic read_reg(input addr_t addr, output logic [31:0] data);
        int waited;
        @(posedge clk_i);
        araddr <= addr;
        arvalid <= 1'b1;
        rready <= 1'b1;
        waited = 0;
        do begin
            @(negedge clk_i);
            waited++;
        end while (!arready && waited < HS_TIMEOUT);
        if (!arready) abort_run("read address ready");
        @(posedge clk_i);
        arvalid <= 1'b0;
        waited = 0;
        do begin
            @(negedge clk_i);
            waited++;
        end while (!rvalid && waited < HS_TIMEOUT);
        if (!rvalid) abort_run("read data");
        data = rdata; // sampled mid-cycle, before the handshake edge.
        @(posedge clk_i);
        rready <= 1'b0;
    endtask

    task automatic add_triangle(input int idx, input int x0, input int y0, input int x1,
                                input int y1, input int x2, input int y2,
                                input bit culled, input int nfrag);
        tri_v[idx][0] = x0;
        tri_v[idx][1] = y0;
        tri_v[idx][2] = x1;
        tri_v[idx][3] = y1;
        tri_v[idx][4] = x2;
        tri_v[idx][5] = y2;
        tri_culled[idx] = culled;
        tri_nfrag[idx] = nfrag;
    endtask

    // pixels in scan order whose three weights are all non-negative.
    task automatic build_model(input int idx);
        longint x0, y0, x1, y1, x2, y2, det, e0, e1, l0, l1, l2;
        int bx0, bx1, by0, by1;
        x0 = tri_v[idx][0];
        y0 = tri_v[idx][1];
        x1 = tri_v[idx][2];
        y1 = tri_v[idx][3];
        x2 = tri_v[idx][4];
        y2 = tri_v[idx][5];
        exp_x.delete();
        exp_y.delete();
        exp_l0.delete();
        exp_l1.delete();
        det = (y1 - y2) * (x0 - x2) + (x2 - x1) * (y0 - y2);
        bx0 = (x0 < x1) ? ((x0 < x2) ? x0 : x2) : ((x1 < x2) ? x1 : x2);
        bx1 = (x0 > x1) ? ((x0 > x2) ? x0 : x2) : ((x1 > x2) ? x1 : x2);
        by0 = (y0 < y1) ? ((y0 < y2) ? y0 : y2) : ((y1 < y2) ? y1 : y2);
        by1 = (y0 > y1) ? ((y0 > y2) ? y0 : y2) : ((y1 > y2) ? y1 : y2);
        if (bx1 > `SCREEN_W - 1) bx1 = `SCREEN_W - 1;
        if (by1 > `SCREEN_H - 1) by1 = `SCREEN_H - 1;
        if (det > 0) begin // a non-positive area means the triangle is culled.
            for (int y = by0; y <= by1; y++) begin
                for (int x = bx0; x <= bx1; x++) begin
                    e0 = (y1 - y2) * (x - x2) + (x2 - x1) * (y - y2);
                    e1 = (y2 - y0) * (x - x2) + (x0 - x2) * (y - y2);
                    l0 = (e0 * ONE) / det; // exact, det is a power of two.
                    l1 = (e1 * ONE) / det;
                    l2 = ONE - l0 - l1;
                    if (l0 >= 0 && l1 >= 0 && l2 >= 0) begin
                        exp_x.push_back(x);
                        exp_y.push_back(y);
                        exp_l0.push_back(l0);
                        exp_l1.push_back(l1);
                    end
                end
            end
        end
    endtask

    task automatic wait_for_full();
        logic [31:0] status;
        int polls;
        polls = 0;
        do begin
            read_reg(REG_STATUS, status);
            polls++;
        end while (!(status[0] && status[8 +: CW] == `FRAG_DEPTH) && polls < RUN_TIMEOUT);
        if (!(status[0] && status[8 +: CW] == `FRAG_DEPTH)) begin
            $display("the FIFO never filled up while the scanner was busy, at %0t", $time);
            test_errors++;
        end else begin
            // the scanner must stall for longer than one pixel time.
            repeat (4) begin
                read_reg(REG_STATUS, status);
                if (status[0] != 1'b1) report_mismatch("busy with a full FIFO", status[0], 1);
                if (status[8 +: CW] != `FRAG_DEPTH)
                    report_mismatch("count with a full FIFO", status[8 +: CW], `FRAG_DEPTH);
            end
        end
    endtask

    task automatic run_triangle(input int idx, input int dx, input int dy, input string name);
        logic [31:0] status;
        logic [31:0] pos;
        logic [31:0] l0;
        logic [31:0] l1;
        logic [31:0] l2;
        longint w0, w1, w2;
        int got, polls, fx, fy;
        bit done;
        test_errors = 0;
        build_model(idx);
        if (exp_x.size() != tri_nfrag[idx])
            report_mismatch("model fragment count", exp_x.size(), tri_nfrag[idx]);
        write_reg(REG_V0X, fix_word(tri_v[idx][0] + dx));
        write_reg(REG_V0Y, fix_word(tri_v[idx][1] + dy));
        write_reg(REG_V1X, fix_word(tri_v[idx][2] + dx));
        write_reg(REG_V1Y, fix_word(tri_v[idx][3] + dy));
        write_reg(REG_V2X, fix_word(tri_v[idx][4] + dx));
        write_reg(REG_V2Y, fix_word(tri_v[idx][5] + dy));
        write_reg(REG_CTRL, 32'h1);
        if (tri_nfrag[idx] > `FRAG_DEPTH) wait_for_full();
        got = 0;
        done = 1'b0;
        polls = 0;
        while (!done && polls < RUN_TIMEOUT) begin
            polls++;
            read_reg(REG_STATUS, status);
            read_reg(REG_FRAG_POS, pos);
            if (pos[31]) begin
                read_reg(REG_FRAG_L0, l0);
                read_reg(REG_FRAG_L1, l1);
                read_reg(REG_FRAG_L2, l2);
                write_reg(REG_FRAG_POP, 32'h0);
                fx = pos[8:0];
                fy = pos[24:16];
                w0 = $signed(l0);
                w1 = $signed(l1);
                w2 = $signed(l2);
                if (got >= exp_x.size()) begin
                    $display("** Error at %0t: extra fragment at (%0d, %0d)", $time, fx, fy);
                    test_errors++;
                end else begin
                    if (fx != exp_x[got] + dx) report_mismatch("fragment x", fx, exp_x[got] + dx);
                    if (fy != exp_y[got] + dy) report_mismatch("fragment y", fy, exp_y[got] + dy);
                    if (w0 != exp_l0[got]) report_mismatch("weight l0", w0, exp_l0[got]);
                    if (w1 != exp_l1[got]) report_mismatch("weight l1", w1, exp_l1[got]);
                end
                if (w0 + w1 + w2 != ONE) report_mismatch("weight sum", w0 + w1 + w2, ONE);
                got++;
            end else if (!status[0]) begin
                done = 1'b1; // idle and drained.
            end
        end
        if (!done) begin
            abort_run("the end of a raster run");
        end else begin
            if (got != exp_x.size()) report_mismatch("fragment count", got, exp_x.size());
            if (status[1] != tri_culled[idx])
                report_mismatch("culled flag", status[1], tri_culled[idx]);
            if (status[8 +: CW] != 0) report_mismatch("final FIFO count", status[8 +: CW], 0);
            close_test(name);
        end
    endtask

    initial begin
        logic [31:0] data;
        logic [31:0] word;
        logic [31:0] r;
        int i;
        nrst_i = 1'b0;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wvalid = 1'b0;
        bready = 1'b0;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        errors = 0;
        test_errors = 0;
        tests_run = 0;
        tests_failed = 0;
        rng_state = 32'd5;
        add_triangle(0, 10, 10, 12, 10, 10, 12, 1'b0, 6);
        add_triangle(1, 2, 2, 6, 2, 2, 6, 1'b0, 15);
        add_triangle(2, 20, 5, 28, 9, 20, 9, 1'b0, 25);
        add_triangle(3, 2, 2, 2, 6, 6, 2, 1'b1, 0);   // triangle 1 wound the other way.
        repeat (2) @(posedge clk_i);
        nrst_i <= 1'b1;

        read_reg(REG_STATUS, data);
        if (data[0] != 1'b0) report_mismatch("busy after reset", data[0], 0);
        if (data[8 +: CW] != 0) report_mismatch("count after reset", data[8 +: CW], 0);
        for (i = 0; i < 6; i++) begin
            word = next_random();
            write_reg(addr_t'(REG_V0X + 4 * i), word);
            read_reg(addr_t'(REG_V0X + 4 * i), data);
            if (data != word) report_mismatch("vertex register readback", data, word);
        end
        close_test("register access");

        for (i = 0; i < NUM_TRI; i++) begin
            run_triangle(i, 0, 0, $sformatf("triangle %0d", i));
        end

        for (i = 0; i < 3; i++) begin
            r = next_random();
            run_triangle(2, r[5:0], r[13:8],
                         $sformatf("random placement %0d at (+%0d, +%0d)", i, r[5:0], r[13:8]));
        end

        $display("summary: %0d tests, %0d failing, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+src
src/raster_pkg.sv
src/bary_pipe.sv
src/raster_scan.sv
src/frag_fifo.sv
src/raster_regs.sv
src/raster_top.sv
verif/tb_raster.sv
